// File: common/mm_data_pkg.sv
// Matrix dimensions, Q8.8 element, row and weight matrix types, accumulator limits
`default_nettype none

package mm_data_pkg;

    localparam int DIM       = 4;                    // Rows, columns and inner dimension
    localparam int ELEM_W    = 16;
    localparam int FRAC_BITS = 8;                    // Q8.8
    localparam int ROW_W     = DIM * ELEM_W;         // One stream beat
    localparam int PROD_W    = 2 * ELEM_W;           // Full width product
    localparam int ACC_W     = PROD_W + $clog2(DIM); // Sum of DIM products, no overflow
    localparam int ELEM_MAX  = 32767;                // Saturation limits of elem_t
    localparam int ELEM_MIN  = -32768;

    typedef logic signed [ELEM_W-1:0] elem_t;

    // Element k sits at bits 16k+15 down to 16k
    typedef elem_t [DIM-1:0] row_t;

    // Row j of W sits at bits 64j+63 down to 64j
    typedef row_t [DIM-1:0] wmat_t;

    typedef logic signed [PROD_W-1:0] prod_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

endpackage

`default_nettype wire

// File: common/mm_ctrl_pkg.sv
// Control state enum, index and FIFO count types, FIFO depths, MAC pipeline latency
`default_nettype none

package mm_ctrl_pkg;

    localparam int IN_FIFO_DEPTH  = 8;   // fifo_i and fifo_w
    localparam int OUT_FIFO_DEPTH = 8;
    localparam int MAC_LATENCY    = 2;   // Issue edge to push edge

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,               // Wait for a full matrix in both FIFOs
        ST_LOAD    = 2'd1,               // Copy four weight rows
        ST_COMPUTE = 2'd2                // Issue four input rows
    } mm_state_e;

    // Row or beat index within one matrix
    typedef logic [1:0] idx_t;

    // Occupancy 0..8
    typedef logic [3:0] fifo_count_t;

endpackage

`default_nettype wire

// File: hdl/stream_fifo.sv
// Synchronous show-ahead FIFO with valid/ready ports and occupancy count
`default_nettype none
`timescale 1ns/1ps

module stream_fifo #(
    parameter int WIDTH = 64,
    parameter int DEPTH = 8
) (
    input  wire                       aclk,
    input  wire                       aresetn,
    input  wire [WIDTH-1:0]           in_data,
    input  wire                       in_valid,
    output logic                      in_ready,
    output logic [WIDTH-1:0]          out_data,
    output logic                      out_valid,
    input  wire                       out_ready,
    output mm_ctrl_pkg::fifo_count_t  count
);
    import mm_ctrl_pkg::*;

    logic [WIDTH-1:0]         mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic                     push;
    logic                     pop;

    assign in_ready  = (count != fifo_count_t'(DEPTH)); // Not full
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];                     // Head shown ahead
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge aclk)
    begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;                // Wraps since DEPTH is a power of two
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                // Idle or push with pop
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/word_counter.sv
// Modulo-4 beat and row index counter with final value flag
`default_nettype none
`timescale 1ns/1ps

module word_counter (
    input  wire                aclk,
    input  wire                aresetn,
    input  wire                step,
    output mm_ctrl_pkg::idx_t  value,
    output logic               last
);
    import mm_data_pkg::*;
    import mm_ctrl_pkg::*;

    // Shared by the load phase and the compute phase
    assign last = (value == idx_t'(DIM - 1));

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
            value <= '0;
        else if (step)
            value <= value + 1'b1; // 3 wraps to 0
    end

endmodule

`default_nettype wire

// File: hdl/mm_ctrl_fsm.sv
// Control FSM for weight loading and row issue, driven by FIFO occupancy
`default_nettype none
`timescale 1ns/1ps

module mm_ctrl_fsm (
    input  wire                       aclk,
    input  wire                       aresetn,
    input  wire mm_ctrl_pkg::fifo_count_t in_count,
    input  wire mm_ctrl_pkg::fifo_count_t w_count,
    input  wire mm_ctrl_pkg::fifo_count_t out_count,
    input  wire                       cnt_last,
    output logic                      cnt_step,
    output logic                      load_en,
    output logic                      issue,
    output logic                      issue_last
);
    import mm_data_pkg::*;
    import mm_ctrl_pkg::*;

    mm_state_e state;
    mm_state_e state_next;
    logic      data_ready;
    logic      space_ok;

    // A whole matrix of A and of W is buffered
    assign data_ready = (in_count >= fifo_count_t'(DIM)) && (w_count >= fifo_count_t'(DIM));

    // Room for this row plus the rows still in the MAC pipeline
    assign space_ok = (out_count <= fifo_count_t'(OUT_FIFO_DEPTH - MAC_LATENCY - 1));

    assign load_en    = (state == ST_LOAD);              // Pops fifo_w
    assign issue      = (state == ST_COMPUTE) && space_ok; // Pops fifo_i
    assign issue_last = issue && cnt_last;
    assign cnt_step   = load_en || issue;

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
            state <= ST_IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:
            begin
                if (data_ready)
                    state_next = ST_LOAD;
            end
            ST_LOAD:
            begin
                if (cnt_last)                            // Fourth weight row
                    state_next = ST_COMPUTE;
            end
            ST_COMPUTE:
            begin
                if (issue_last)
                    state_next = ST_IDLE;                // Rows may still be in flight
            end
            default:
            begin
                state_next = ST_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: matmul/weight_store.sv
// Four-row weight register file, written by index and read in parallel
`default_nettype none
`timescale 1ns/1ps

module weight_store (
    input  wire                      aclk,
    input  wire                      aresetn,
    input  wire                      wr_en,
    input  wire mm_ctrl_pkg::idx_t   wr_idx,
    input  wire mm_data_pkg::row_t   wr_row,
    output mm_data_pkg::wmat_t       weights
);

    // Every row is visible at once, so all four columns of C form in one pass
    always_ff @(posedge aclk)
    begin
        if (!aresetn)
            weights <= '0;
        else if (wr_en)
            weights[wr_idx] <= wr_row; // Row j of W
    end

endmodule

`default_nettype wire

// File: matmul/row_mac_unit.sv
// Two-stage pipeline forming one result row of four Q8.8 dot products
`default_nettype none
`timescale 1ns/1ps

module row_mac_unit (
    input  wire                      aclk,
    input  wire                      aresetn,
    input  wire                      in_valid,
    input  wire                      in_last,
    input  wire mm_data_pkg::row_t   a_row,
    input  wire mm_data_pkg::wmat_t  weights,
    output logic                     out_valid,
    output logic                     out_last,
    output mm_data_pkg::row_t        out_row
);
    import mm_data_pkg::*;

    prod_t prod_q [DIM][DIM]; // [j][k] = A[i][k] * W[j][k]
    logic  valid_q;
    logic  last_q;
    acc_t  sum [DIM];
    acc_t  shifted [DIM];
    row_t  sat_row;

    // Stage one registers sixteen full width products
    always_ff @(posedge aclk)
    begin
        for (int j = 0; j < DIM; j++)
        begin
            for (int k = 0; k < DIM; k++)
            begin
                prod_q[j][k] <= $signed(a_row[k]) * $signed(weights[j][k]);
            end
        end
    end

    // Stage two sums, floor shifts and saturates
    always_comb
    begin
        for (int j = 0; j < DIM; j++)
        begin
            sum[j] = '0;
            for (int k = 0; k < DIM; k++)
            begin
                sum[j] = sum[j] + acc_t'(prod_q[j][k]);
            end
            shifted[j] = sum[j] >>> FRAC_BITS;                // Rounds toward minus infinity
            if (shifted[j] > acc_t'(ELEM_MAX))
                sat_row[j] = elem_t'(ELEM_MAX);
            else if (shifted[j] < acc_t'(ELEM_MIN))
                sat_row[j] = elem_t'(ELEM_MIN);
            else
                sat_row[j] = shifted[j][ELEM_W-1:0];
        end
    end

    always_ff @(posedge aclk)
    begin
        out_row <= sat_row;
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            valid_q   <= 1'b0;
            last_q    <= 1'b0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end
        else
        begin
            valid_q   <= in_valid;
            last_q    <= in_valid && in_last;
            out_valid <= valid_q;                             // Pushes fifo_o directly
            out_last  <= last_q;
        end
    end

endmodule

`default_nettype wire

// File: hdl/axis_matmul_top.sv
// AXI-Stream 4x4 Q8.8 matrix multiply top level with input, weight and output FIFOs
`default_nettype none
`timescale 1ns/1ps

module axis_matmul_top (
    input  wire                     aclk,
    input  wire                     aresetn,
    // Input matrix rows
    input  wire mm_data_pkg::row_t  s_axis_i_tdata,
    input  wire                     s_axis_i_tvalid,
    output logic                    s_axis_i_tready,
    // Weight rows
    input  wire mm_data_pkg::row_t  s_axis_w_tdata,
    input  wire                     s_axis_w_tvalid,
    output logic                    s_axis_w_tready,
    // Result rows
    output mm_data_pkg::row_t       m_axis_tdata,
    output logic                    m_axis_tvalid,
    input  wire                     m_axis_tready,
    output logic                    m_axis_tlast
);
    import mm_data_pkg::*;
    import mm_ctrl_pkg::*;

    row_t         i_data;
    row_t         w_data;
    fifo_count_t  i_count;
    fifo_count_t  w_count;
    fifo_count_t  o_count;
    logic         load_en;
    logic         issue;
    logic         issue_last;
    logic         cnt_step;
    logic         cnt_last;
    idx_t         cnt_value;
    wmat_t        weights;
    logic         mac_valid;
    logic         mac_last;
    row_t         mac_row;
    logic [ROW_W:0] o_data;  // {last, row}

    stream_fifo #(.WIDTH(ROW_W), .DEPTH(IN_FIFO_DEPTH)) fifo_i (
        .aclk(aclk), .aresetn(aresetn),
        .in_data(s_axis_i_tdata), .in_valid(s_axis_i_tvalid), .in_ready(s_axis_i_tready),
        .out_data(i_data), .out_valid(), .out_ready(issue),
        .count(i_count)
    );

    stream_fifo #(.WIDTH(ROW_W), .DEPTH(IN_FIFO_DEPTH)) fifo_w (
        .aclk(aclk), .aresetn(aresetn),
        .in_data(s_axis_w_tdata), .in_valid(s_axis_w_tvalid), .in_ready(s_axis_w_tready),
        .out_data(w_data), .out_valid(), .out_ready(load_en),
        .count(w_count)
    );

    // One index counter for both weight load and row issue
    word_counter u_word_counter (
        .aclk(aclk), .aresetn(aresetn),
        .step(cnt_step), .value(cnt_value), .last(cnt_last)
    );

    mm_ctrl_fsm u_ctrl_fsm (
        .aclk(aclk), .aresetn(aresetn),
        .in_count(i_count), .w_count(w_count), .out_count(o_count),
        .cnt_last(cnt_last), .cnt_step(cnt_step),
        .load_en(load_en), .issue(issue), .issue_last(issue_last)
    );

    weight_store u_weight_store (
        .aclk(aclk), .aresetn(aresetn),
        .wr_en(load_en), .wr_idx(cnt_value), .wr_row(w_data),
        .weights(weights)
    );

    row_mac_unit u_row_mac (
        .aclk(aclk), .aresetn(aresetn),
        .in_valid(issue), .in_last(issue_last), .a_row(i_data), .weights(weights),
        .out_valid(mac_valid), .out_last(mac_last), .out_row(mac_row)
    );

    // Space is reserved by the FSM, so in_ready is never low on a push
    stream_fifo #(.WIDTH(ROW_W + 1), .DEPTH(OUT_FIFO_DEPTH)) fifo_o (
        .aclk(aclk), .aresetn(aresetn),
        .in_data({mac_last, mac_row}), .in_valid(mac_valid), .in_ready(),
        .out_data(o_data), .out_valid(m_axis_tvalid), .out_ready(m_axis_tready),
        .count(o_count)
    );

    assign m_axis_tlast = o_data[ROW_W];
    assign m_axis_tdata = o_data[ROW_W-1:0];

endmodule

`default_nettype wire

// File: tests/axis_matmul_assertions.sv
// Bound concurrent checks on the result stream, the fifo_o push and the FIFO pops of the FSM
`default_nettype none
`timescale 1ns/1ps

module axis_matmul_assertions (
    input  wire                            aclk,
    input  wire                            aresetn,
    input  wire mm_data_pkg::row_t         m_axis_tdata,
    input  wire                            m_axis_tvalid,
    input  wire                            m_axis_tready,
    input  wire                            mac_valid,
    input  wire mm_ctrl_pkg::fifo_count_t  i_count,
    input  wire mm_ctrl_pkg::fifo_count_t  w_count,
    input  wire mm_ctrl_pkg::fifo_count_t  o_count,
    input  wire                            load_en,
    input  wire                            issue
);
    import mm_ctrl_pkg::*;

    // Stalled beat must hold
    stall_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        (m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid && $stable(m_axis_tdata)))
        else $error("m_axis beat changed or dropped while stalled");

    no_push_full: assert property (@(posedge aclk) disable iff (!aresetn)
        mac_valid |-> (o_count != fifo_count_t'(OUT_FIFO_DEPTH)))
        else $error("fifo_o pushed while full");

    // Count rule in ST_IDLE backs every row pop
    issue_has_row: assert property (@(posedge aclk) disable iff (!aresetn)
        issue |-> (i_count != '0))
        else $error("Row issued from an empty fifo_i");

    load_has_row: assert property (@(posedge aclk) disable iff (!aresetn)
        load_en |-> (w_count != '0))
        else $error("Weight row loaded from an empty fifo_w");

endmodule

bind axis_matmul_top axis_matmul_assertions u_assertions (
    .aclk(aclk), .aresetn(aresetn),
    .m_axis_tdata(m_axis_tdata), .m_axis_tvalid(m_axis_tvalid), .m_axis_tready(m_axis_tready),
    .mac_valid(mac_valid), .i_count(i_count), .w_count(w_count), .o_count(o_count),
    .load_en(load_en), .issue(issue)
);

`default_nettype wire

// File: tests/tb_axis_matmul.sv
// Testbench for the matrix multiply top level with LCG stimulus, reference model and scoreboard
`default_nettype none
`timescale 1ns/1ps

module tb_axis_matmul;
    import mm_data_pkg::*;

    localparam logic [31:0] SEED = 32'hcfcc6c09;
    localparam int NUM_MATS       = 40;                  // All phases together
    localparam int TIMEOUT_CYCLES = NUM_MATS * 64 + 200;
    localparam int KIND_SMALL     = 0;                   // About +-4.0
    localparam int KIND_IDENT     = 1;
    localparam int KIND_FULL      = 2;                   // Whole Q8.8 range

    logic        aclk;
    logic        aresetn;
    row_t        s_axis_i_tdata;
    logic        s_axis_i_tvalid;
    logic        s_axis_i_tready;
    row_t        s_axis_w_tdata;
    logic        s_axis_w_tvalid;
    logic        s_axis_w_tready;
    row_t        m_axis_tdata;
    logic        m_axis_tvalid;
    logic        m_axis_tready;
    logic        m_axis_tlast;

    logic [31:0] rng [3];                                // Data and input gaps, weight gaps, tready
    wmat_t       a_mem [$];
    wmat_t       w_mem [$];
    row_t        exp_rows [$];
    logic        exp_last [$];
    string       test_name;
    bit          bp_mode;
    int          hold_cnt;
    int          cycle_count;

    axis_matmul_top dut (
        .aclk(aclk), .aresetn(aresetn),
        .s_axis_i_tdata(s_axis_i_tdata), .s_axis_i_tvalid(s_axis_i_tvalid),
        .s_axis_i_tready(s_axis_i_tready),
        .s_axis_w_tdata(s_axis_w_tdata), .s_axis_w_tvalid(s_axis_w_tvalid),
        .s_axis_w_tready(s_axis_w_tready),
        .m_axis_tdata(m_axis_tdata), .m_axis_tvalid(m_axis_tvalid),
        .m_axis_tready(m_axis_tready), .m_axis_tlast(m_axis_tlast)
    );

    always #10 aclk = ~aclk;

    function automatic logic [31:0] next_rand(input int id);
        rng[id] = rng[id] * 32'd1664525 + 32'd1013904223;
        return rng[id];
    endfunction

    function automatic wmat_t make_matrix(input int kind);
        wmat_t       m;
        logic [31:0] r;
        for (int i = 0; i < DIM; i++)
        begin
            for (int k = 0; k < DIM; k++)
            begin
                r = next_rand(0);
                case (kind)
                    KIND_SMALL: m[i][k] = elem_t'($signed(r[31:16]) >>> 5);
                    KIND_IDENT: m[i][k] = (i == k) ? elem_t'(256) : elem_t'(0); // 1.0
                    default:    m[i][k] = elem_t'(r[31:16]);
                endcase
            end
        end
        return m;
    endfunction

    // C[i][j] is the sum over k of A[i][k] * W[j][k] with floor shift and saturation
    function automatic void ref_matmul(input wmat_t a, input wmat_t w);
        longint acc;
        row_t   row;
        for (int i = 0; i < DIM; i++)
        begin
            for (int j = 0; j < DIM; j++)
            begin
                acc = 0;
                for (int k = 0; k < DIM; k++)
                    acc += longint'(a[i][k]) * longint'(w[j][k]);
                acc = acc >>> FRAC_BITS;
                if (acc > 32767)
                    row[j] = 16'sh7fff;
                else if (acc < -32768)
                    row[j] = 16'sh8000;
                else
                    row[j] = acc[15:0];
            end
            exp_rows.push_back(row);
            exp_last.push_back(i == DIM - 1);
        end
    endfunction

    function automatic void add_matrix(input int kind_a, input int kind_w);
        wmat_t a;
        wmat_t w;
        a = make_matrix(kind_a);
        w = make_matrix(kind_w);
        a_mem.push_back(a);
        w_mem.push_back(w);
        ref_matmul(a, w);
    endfunction

    task automatic check_row(input string name, input row_t exp, input row_t act);
        if (exp !== act)
        begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            $display("Errors found");
            $fatal(1, "Result row mismatch");
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("Fail %s: expected tlast %b, actual %b", name, exp, act);
            $display("Errors found");
            $fatal(1, "tlast mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            $display("Errors found");
            $fatal(1, "Control output mismatch");
        end
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic feed(input bit is_w, input int first, input int n, input int start_delay,
                        input int gap_pct);
        row_t beat;
        logic accepted;
        repeat (start_delay)
        begin
            @(posedge aclk);
            #1;
        end
        for (int m = first; m < first + n; m++)
        begin
            for (int r = 0; r < DIM; r++)
            begin
                beat = is_w ? w_mem[m][r] : a_mem[m][r];
                while (gap_pct > 0 && ((next_rand(is_w) >> 16) % 100) < gap_pct)
                begin
                    if (is_w) s_axis_w_tvalid = 1'b0;
                    else      s_axis_i_tvalid = 1'b0;
                    @(posedge aclk);
                    #1;
                end
                if (is_w)
                begin
                    s_axis_w_tdata  = beat;
                    s_axis_w_tvalid = 1'b1;
                end
                else
                begin
                    s_axis_i_tdata  = beat;
                    s_axis_i_tvalid = 1'b1;
                end
                accepted = 1'b0;
                while (!accepted)
                begin
                    accepted = is_w ? s_axis_w_tready : s_axis_i_tready; // Fixed until the edge
                    @(posedge aclk);
                    #1;
                end
            end
        end
        if (is_w) s_axis_w_tvalid = 1'b0;
        else      s_axis_i_tvalid = 1'b0;
    endtask

    task automatic drain();
        while (exp_rows.size() != 0)
        begin
            @(posedge aclk);
            #1;
        end
    endtask

    task automatic run_phase(input string name, input int n, input int kind_a, input int kind_w,
                             input int gap_pct, input bit bp);
        int first;
        first     = a_mem.size();
        test_name = name;
        bp_mode   = bp;
        for (int m = 0; m < n; m++)
            add_matrix(kind_a, kind_w);
        fork
            feed(1'b0, first, n, 0, gap_pct);
            feed(1'b1, first, n, 0, gap_pct);
        join
        drain();
        bp_mode = 1'b0;
    endtask

    // Random tready with occasional long low stretches
    always @(posedge aclk)
    begin
        logic [31:0] r;
        #1;
        if (!bp_mode)
            m_axis_tready = 1'b1;
        else if (hold_cnt > 0)
            hold_cnt--;
        else
        begin
            r = next_rand(2);
            if (r[31:28] == 4'd0)
            begin
                m_axis_tready = 1'b0;
                hold_cnt      = 16 + (r[15:8] % 24);
            end
            else
                m_axis_tready = r[20];
        end
    end

    // Scoreboard samples at the falling edge where the stream is stable
    always @(negedge aclk)
    begin
        if (aresetn && m_axis_tvalid && m_axis_tready)
        begin
            if (exp_rows.size() == 0)
            begin
                $display("Unexpected output beat in %s with no result pending", test_name);
                $display("Errors found");
                $fatal(1, "Extra output beat");
            end
            else
            begin
                check_row(test_name, exp_rows.pop_front(), m_axis_tdata);
                check_last(test_name, exp_last.pop_front(), m_axis_tlast);
            end
        end
    end

    always @(posedge aclk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles with %0d result rows still missing",
                     cycle_count, exp_rows.size());
            $display("Errors found");
            $fatal(1, "Timeout");
        end
    end

    initial
    begin
        int first;
        aclk            = 1'b0;
        aresetn         = 1'b0;
        s_axis_i_tdata  = '0;
        s_axis_i_tvalid = 1'b0;
        s_axis_w_tdata  = '0;
        s_axis_w_tvalid = 1'b0;
        m_axis_tready   = 1'b1;
        bp_mode         = 1'b0;
        hold_cnt        = 0;
        cycle_count     = 0;
        rng[0]          = SEED;
        rng[1]          = SEED ^ 32'h5bd1e995;
        rng[2]          = SEED ^ 32'h1b873593;

        test_name = "reset";
        repeat (8)
        begin
            @(posedge aclk);
            #1;
        end
        check_flag("reset tvalid", 1'b0, m_axis_tvalid);
        check_flag("reset i_tready", 1'b1, s_axis_i_tready);
        check_flag("reset w_tready", 1'b1, s_axis_w_tready);
        aresetn = 1'b1;
        @(posedge aclk);
        #1;
        check_flag("after reset tvalid", 1'b0, m_axis_tvalid);
        check_flag("after reset i_tready", 1'b1, s_axis_i_tready);
        check_flag("after reset w_tready", 1'b1, s_axis_w_tready);

        run_phase("identity", 2, KIND_SMALL, KIND_IDENT, 0, 1'b0);
        run_phase("random", 20, KIND_SMALL, KIND_SMALL, 0, 1'b0);
        run_phase("saturation", 4, KIND_FULL, KIND_FULL, 0, 1'b0);
        run_phase("backpressure", 10, KIND_SMALL, KIND_SMALL, 20, 1'b1);

        // Weights well ahead of inputs, then inputs well ahead of weights
        test_name = "unbalanced";
        for (int m = 0; m < 4; m++)
        begin
            first = a_mem.size();
            add_matrix(KIND_SMALL, KIND_SMALL);
            fork
                feed(1'b0, first, 1, (m < 2) ? 24 : 0, 40);
                feed(1'b1, first, 1, (m < 2) ? 0 : 24, 40);
            join
        end
        drain();

        repeat (10)
        begin
            @(posedge aclk);
            #1;
        end
        if (exp_rows.size() == 0 && !m_axis_tvalid)
        begin
            $display("No errors");
            $finish;
        end
        else
        begin
            $display("Errors found");
            $fatal(1, "Output stream not drained at the end");
        end
    end

endmodule

`default_nettype wire

// File: sources.f
common/mm_data_pkg.sv
common/mm_ctrl_pkg.sv
hdl/stream_fifo.sv
hdl/word_counter.sv
hdl/mm_ctrl_fsm.sv
matmul/weight_store.sv
matmul/row_mac_unit.sv
hdl/axis_matmul_top.sv
tests/axis_matmul_assertions.sv
tests/tb_axis_matmul.sv

// File: Bender.yml
package:
  name: axis_matmul

sources:
  - common/mm_data_pkg.sv
  - common/mm_ctrl_pkg.sv
  - hdl/stream_fifo.sv
  - hdl/word_counter.sv
  - hdl/mm_ctrl_fsm.sv
  - matmul/weight_store.sv
  - matmul/row_mac_unit.sv
  - hdl/axis_matmul_top.sv
  - target: test
    files:
      - tests/axis_matmul_assertions.sv
      - tests/tb_axis_matmul.sv
